/* rtl/uart_cmd_consts.svh */
`ifndef UART_CMD_CONSTS_SVH
`define UART_CMD_CONSTS_SVH

// clock cycles per serial bit at the default baud rate.
`define UART_BIT_CYCLES 434

// idle bit times between the high and low frames of a write.
`define UART_GAP_BITS 2

// bit times to wait for the first start bit of a read reply.
`define UART_RESP_BITS 64

// command bit that selects write (1) or read (0).
`define UART_CMD_WRITE_BIT 15

`endif

/* rtl/uart_cmd_pkg.sv */
package uart_cmd_pkg;

  // payload of one serial frame.
  typedef logic [7:0] uart_byte_t;

  // host command.
  // bit 15 is the write flag, 14..8 the address, 7..0 the write data.
  typedef logic [15:0] uart_cmd_t;

  // even parity bit for one payload byte.
  function automatic logic uart_even_parity(uart_byte_t b);
    return ^b;
  endfunction

endpackage

/* rtl/uart_tx_engine.sv */
`timescale 1ns/1ps
`include "uart_cmd_consts.svh"

module uart_tx_engine
  import uart_cmd_pkg::*;
#(
  parameter int bit_cycles = `UART_BIT_CYCLES
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  uart_byte_t tx_byte,
  output logic       tx_done,
  output logic       tx
);

  localparam int baud_w = $clog2(bit_cycles);

  logic              busy;
  logic [3:0]        bit_cnt;
  logic [baud_w-1:0] baud_cnt;
  logic [9:0]        shreg;
  logic              bit_end;

  assign bit_end = (baud_cnt == baud_w'(bit_cycles - 1));

  // bit 10 of the frame is the stop bit.
  assign tx_done = busy && bit_end && (bit_cnt == 4'd10);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      bit_cnt  <= '0;
      baud_cnt <= '0;
      tx       <= 1'b1;
    end else if (!busy) begin
      if (tx_start) begin
        busy     <= 1'b1;
        bit_cnt  <= '0;
        baud_cnt <= '0;
        tx       <= 1'b0;
      end
    end else if (bit_end) begin
      baud_cnt <= '0;
      if (bit_cnt == 4'd10) begin
        busy <= 1'b0;
        tx   <= 1'b1;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
        tx      <= shreg[0];
      end
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // remaining bits after the start bit: data lsb first, parity, stop.
  always_ff @(posedge clk) begin
    if (!busy && tx_start) begin
      shreg <= {1'b1, uart_even_parity(tx_byte), tx_byte};
    end else if (busy && bit_end) begin
      shreg <= {1'b1, shreg[9:1]};
    end
  end

  // the sequencer only starts a frame once the previous one is done.
  a_no_start_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
    busy |-> !tx_start
  );

  // the line is idle high between frames.
  a_idle_high: assert property (
    @(posedge clk) disable iff (!rst_n)
    !busy |-> tx
  );

endmodule

/* rtl/uart_rx_engine.sv */
`timescale 1ns/1ps
`include "uart_cmd_consts.svh"

module uart_rx_engine
  import uart_cmd_pkg::*;
#(
  parameter int bit_cycles = `UART_BIT_CYCLES
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx_arm,
  input  logic       rx,
  output uart_byte_t rx_byte,
  output logic       rx_done,
  output logic       rx_perr,
  output logic       rx_timeout
);

  localparam int baud_w      = $clog2(bit_cycles);
  localparam int half_cycles = bit_cycles / 2;
  localparam int resp_cycles = `UART_RESP_BITS * bit_cycles;
  localparam int tmo_w       = $clog2(resp_cycles);

  typedef enum logic [2:0] {
    s_idle,
    s_hunt,
    s_start,
    s_data,
    s_parity,
    s_stop
  } state_t;

  state_t            state;
  logic              rx_s1;
  logic              rx_s2;
  logic              rx_q;
  logic              fall;
  logic [baud_w-1:0] baud_cnt;
  logic [2:0]        bit_cnt;
  logic [tmo_w-1:0]  tmo_cnt;
  logic              tmo_end;
  logic              bit_end;
  logic              par_bit;

  // two-flop synchronizer, plus one more stage for edge detection.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_q  <= 1'b1;
    end else begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_q  <= rx_s2;
    end
  end

  assign fall    = rx_q && !rx_s2;
  assign tmo_end = (tmo_cnt == tmo_w'(resp_cycles - 1));
  assign bit_end = (baud_cnt == baud_w'(bit_cycles - 1));

  assign rx_done    = (state == s_stop) && bit_end;
  assign rx_perr    = rx_done && (par_bit != uart_even_parity(rx_byte));
  assign rx_timeout = (state == s_hunt) && !fall && tmo_end;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= s_idle;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tmo_cnt  <= '0;
    end else begin
      case (state)
        s_idle: begin
          if (rx_arm) begin
            state   <= s_hunt;
            tmo_cnt <= '0;
          end
        end
        s_hunt: begin
          if (fall) begin
            state    <= s_start;
            baud_cnt <= '0;
          end else if (tmo_end) begin
            state <= s_idle;
          end else begin
            tmo_cnt <= tmo_cnt + 1'b1;
          end
        end
        s_start: begin
          // a glitch that is gone by mid-bit is not a start bit.
          if (baud_cnt == baud_w'(half_cycles - 1)) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            state    <= rx_s2 ? s_hunt : s_data;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        s_data: begin
          if (bit_end) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= s_parity;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        s_parity: begin
          if (bit_end) begin
            baud_cnt <= '0;
            state    <= s_stop;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        s_stop: begin
          if (bit_end) begin
            state <= s_idle;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  // data arrives lsb first.
  always_ff @(posedge clk) begin
    if ((state == s_data) && bit_end) begin
      rx_byte <= {rx_s2, rx_byte[7:1]};
    end
    if ((state == s_parity) && bit_end) begin
      par_bit <= rx_s2;
    end
  end

  a_one_result: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(rx_done && rx_timeout)
  );

  // one result per arm, nothing more until armed again.
  a_result_needs_arm: assert property (
    @(posedge clk) disable iff (!rst_n)
    (rx_done || rx_timeout) |=> !(rx_done || rx_timeout) until rx_arm
  );

endmodule

/* rtl/uart_cmd_sequencer.sv */
`timescale 1ns/1ps
`include "uart_cmd_consts.svh"

module uart_cmd_sequencer
  import uart_cmd_pkg::*;
#(
  parameter int bit_cycles = `UART_BIT_CYCLES
) (
  input  logic       clk,
  input  logic       rst_n,
  input  uart_cmd_t  cmd_in,
  input  logic       cmd_vld,
  output logic       cmd_rdy,
  output logic       tx_start,
  output uart_byte_t tx_byte,
  input  logic       tx_done,
  output logic       rx_arm,
  input  uart_byte_t rx_byte,
  input  logic       rx_done,
  input  logic       rx_perr,
  input  logic       rx_timeout,
  output uart_byte_t read_data,
  output logic       read_rdy,
  output logic       read_err
);

  localparam int gap_cycles = `UART_GAP_BITS * bit_cycles;
  localparam int gap_w      = $clog2(gap_cycles);

  typedef enum logic [2:0] {
    s_idle,
    s_send_hi,
    s_gap,
    s_send_lo,
    s_wait_rsp
  } state_t;

  state_t           state;
  logic [gap_w-1:0] gap_cnt;
  logic             gap_end;
  logic             cmd_take;
  logic             is_write;
  uart_byte_t       lo_byte;

  assign cmd_rdy  = (state == s_idle);
  assign cmd_take = cmd_vld && cmd_rdy;
  assign gap_end  = (state == s_gap) && (gap_cnt == gap_w'(gap_cycles - 1));

  // high byte goes straight from the host so the frame starts next cycle.
  assign tx_start = cmd_take || gap_end;
  assign tx_byte  = cmd_rdy ? cmd_in[15:8] : lo_byte;

  // a read arms the receiver as the address frame ends.
  assign rx_arm = (state == s_send_hi) && tx_done && !is_write;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= s_idle;
      gap_cnt  <= '0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
    end else begin
      read_rdy <= 1'b0;
      read_err <= 1'b0;
      case (state)
        s_idle: begin
          if (cmd_vld) begin
            state <= s_send_hi;
          end
        end
        s_send_hi: begin
          if (tx_done) begin
            if (is_write) begin
              state   <= s_gap;
              gap_cnt <= '0;
            end else begin
              state <= s_wait_rsp;
            end
          end
        end
        s_gap: begin
          if (gap_end) begin
            state <= s_send_lo;
          end else begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        s_send_lo: begin
          if (tx_done) begin
            state <= s_idle;
          end
        end
        s_wait_rsp: begin
          if (rx_done || rx_timeout) begin
            state    <= s_idle;
            read_rdy <= rx_done && !rx_perr;
            read_err <= rx_timeout || (rx_done && rx_perr);
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_take) begin
      is_write <= cmd_in[`UART_CMD_WRITE_BIT];
      lo_byte  <= cmd_in[7:0];
    end
    if ((state == s_wait_rsp) && rx_done) begin
      read_data <= rx_byte;
    end
  end

  a_one_outcome: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(read_rdy && read_err)
  );

endmodule

/* rtl/uart_cmd_master.sv */
`timescale 1ns/1ps
`include "uart_cmd_consts.svh"

module uart_cmd_master
  import uart_cmd_pkg::*;
#(
  parameter int bit_cycles = `UART_BIT_CYCLES
) (
  input  logic       clk,
  input  logic       rst_n,
  input  uart_cmd_t  cmd_in,
  input  logic       cmd_vld,
  output logic       cmd_rdy,
  input  logic       rx,
  output logic       tx,
  output uart_byte_t read_data,
  output logic       read_rdy,
  output logic       read_err
);

  logic       tx_start;
  uart_byte_t tx_byte;
  logic       tx_done;
  logic       rx_arm;
  uart_byte_t rx_byte;
  logic       rx_done;
  logic       rx_perr;
  logic       rx_timeout;

  uart_cmd_sequencer #(
    .bit_cycles(bit_cycles)
  ) uart_cmd_sequencer_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_done   (tx_done),
    .rx_arm    (rx_arm),
    .rx_byte   (rx_byte),
    .rx_done   (rx_done),
    .rx_perr   (rx_perr),
    .rx_timeout(rx_timeout),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  uart_tx_engine #(
    .bit_cycles(bit_cycles)
  ) uart_tx_engine_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_start(tx_start),
    .tx_byte (tx_byte),
    .tx_done (tx_done),
    .tx      (tx)
  );

  uart_rx_engine #(
    .bit_cycles(bit_cycles)
  ) uart_rx_engine_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_arm    (rx_arm),
    .rx        (rx),
    .rx_byte   (rx_byte),
    .rx_done   (rx_done),
    .rx_perr   (rx_perr),
    .rx_timeout(rx_timeout)
  );

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int period       = 4,
  parameter int reset_cycles = 5
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // reset held low for a fixed number of rising edges.
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

/* tb/tb_uart_cmd_master.sv */
`timescale 1ns/1ps
`include "uart_cmd_consts.svh"

module tb_uart_cmd_master
  import uart_cmd_pkg::*;
();

  localparam int bit_cycles   = 8;
  localparam int wait_limit   = 2 * (`UART_RESP_BITS + 40) * bit_cycles;
  localparam int mode_ok      = 0;
  localparam int mode_bad_par = 1;
  localparam int mode_silent  = 2;

  logic       clk;
  logic       rst_n;
  uart_cmd_t  cmd_in;
  logic       cmd_vld;
  logic       cmd_rdy;
  logic       rx;
  logic       tx;
  uart_byte_t read_data;
  logic       read_rdy;
  logic       read_err;

  uart_byte_t  exp_frame_q[$];
  uart_byte_t  exp_read_q[$];
  uart_byte_t  frame_q[$];
  uart_byte_t  reply_q[$];
  int          reply_mode_q[$];
  int          reply_mode      = mode_ok;
  int          errs_expected   = 0;
  int          seq_cnt         = 0;
  int          cycle           = 0;
  int          frame_end_cycle = 0;
  int          err_cycle       = 0;
  logic [31:0] rng             = 32'hb210;

  tb_clk_gen #(
    .period      (4),
    .reset_cycles(5)
  ) tb_clk_gen_inst (
    .clk  (clk),
    .rst_n(rst_n)
  );

  uart_cmd_master #(
    .bit_cycles(bit_cycles)
  ) uart_cmd_master_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .rx       (rx),
    .tx       (tx),
    .read_data(read_data),
    .read_rdy (read_rdy),
    .read_err (read_err)
  );

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic uart_cmd_t make_cmd(input logic wr, input logic pick_random);
    logic flag;
    rng  = lcg(rng);
    flag = pick_random ? rng[31] : wr;
    return {flag, rng[30:16]};
  endfunction

  // reply byte the slave returns for an address byte.
  function automatic uart_byte_t ref_reply(input uart_byte_t addr);
    return ({addr[4:0], addr[7:5]} ^ 8'ha5) + 8'd17;
  endfunction

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("ERROR: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // serial slave that decodes frames on tx at mid-bit.
  initial begin : serial_slave
    uart_byte_t data;
    logic       start_bit;
    logic       par_bit;
    logic       stop_bit;
    logic       expect_low;
    expect_low = 1'b0;
    forever begin
      @(posedge clk);
      if (rst_n && (tx === 1'b0)) begin
        repeat (bit_cycles / 2 - 1) @(posedge clk);
        start_bit = tx;
        for (int i = 0; i < 8; i++) begin
          repeat (bit_cycles) @(posedge clk);
          data[i] = tx;
        end
        repeat (bit_cycles) @(posedge clk);
        par_bit = tx;
        repeat (bit_cycles) @(posedge clk);
        stop_bit = tx;
        check_val("tx_start_bit", start_bit, 1'b0);
        check_val("tx_parity", par_bit, ^data);
        check_val("tx_stop_bit", stop_bit, 1'b1);
        frame_q.push_back(data);
        frame_end_cycle = cycle;
        if (expect_low) begin
          expect_low = 1'b0;
          seq_cnt++;
        end else if (data[7]) begin
          expect_low = 1'b1;
        end else begin
          reply_q.push_back(data);
          reply_mode_q.push_back(reply_mode);
          seq_cnt++;
        end
      end
    end
  end

  // answers read address frames on rx.
  initial begin : reply_driver
    uart_byte_t  addr;
    uart_byte_t  data;
    int          mode;
    logic [10:0] frame;
    forever begin
      @(posedge clk);
      if (reply_q.size() > 0) begin
        addr = reply_q.pop_front();
        mode = reply_mode_q.pop_front();
        if (mode != mode_silent) begin
          repeat (2 * bit_cycles) @(posedge clk);
          data  = ref_reply(addr);
          frame = {1'b1, (^data) ^ (mode == mode_bad_par), data, 1'b0};
          for (int i = 0; i < 11; i++) begin
            rx <= frame[i];
            repeat (bit_cycles) @(posedge clk);
          end
          rx <= 1'b1;
        end
      end
    end
  end

  always @(negedge clk) begin : compare_outputs
    uart_byte_t got;
    while (frame_q.size() > 0) begin
      got = frame_q.pop_front();
      if (exp_frame_q.size() == 0) begin
        fail_now("serial slave decoded a frame that no command asked for");
      end
      check_val("tx_frame", got, exp_frame_q.pop_front());
    end
    if (rst_n && (read_rdy === 1'b1)) begin
      if (exp_read_q.size() == 0) begin
        fail_now("read_rdy pulsed although no good reply was expected");
      end
      check_val("read_data", read_data, exp_read_q.pop_front());
    end
    if (rst_n && (read_err === 1'b1)) begin
      if (errs_expected == 0) begin
        fail_now("read_err pulsed although no read was expected to fail");
      end
      errs_expected--;
      err_cycle = cycle;
    end
  end

  task automatic expect_cmd(input uart_cmd_t c, input int mode);
    exp_frame_q.push_back(c[15:8]);
    if (c[`UART_CMD_WRITE_BIT]) begin
      exp_frame_q.push_back(c[7:0]);
    end else if (mode == mode_ok) begin
      exp_read_q.push_back(ref_reply(c[15:8]));
    end else begin
      errs_expected++;
    end
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      n++;
      if (n > 100) fail_now("timeout waiting for reset to be released");
    end
  endtask

  task automatic issue_cmd(input uart_cmd_t c);
    int n;
    n = 0;
    @(posedge clk);
    cmd_in  <= c;
    cmd_vld <= 1'b1;
    do begin
      @(posedge clk);
      n++;
      if (n > wait_limit) fail_now("timeout waiting for a command to be taken");
    end while (cmd_rdy !== 1'b1);
    cmd_vld <= 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > wait_limit) fail_now("timeout waiting for cmd_rdy to return high");
    end while (cmd_rdy !== 1'b1);
  endtask

  task automatic check_drained();
    check_val("pending_frames", exp_frame_q.size(), 0);
    check_val("pending_reads", exp_read_q.size(), 0);
    check_val("pending_read_errs", errs_expected, 0);
  endtask

  task automatic run_single(input uart_cmd_t c, input int mode);
    reply_mode = mode;
    expect_cmd(c, mode);
    issue_cmd(c);
    wait_idle();
    check_drained();
  endtask

  // cmd_vld stays high and a new command follows each accepted one.
  task automatic run_back_to_back(input int n);
    int        taken;
    int        waited;
    int        seq_before;
    uart_cmd_t c;
    taken      = 0;
    waited     = 0;
    seq_before = seq_cnt;
    reply_mode = mode_ok;
    c = make_cmd(1'b0, 1'b1);
    expect_cmd(c, mode_ok);
    @(posedge clk);
    cmd_in  <= c;
    cmd_vld <= 1'b1;
    while (taken < n) begin
      @(posedge clk);
      if (cmd_rdy === 1'b1) begin
        taken++;
        waited = 0;
        if (taken < n) begin
          c = make_cmd(1'b0, 1'b1);
          expect_cmd(c, mode_ok);
          cmd_in <= c;
        end else begin
          cmd_vld <= 1'b0;
        end
      end else begin
        waited++;
        if (waited > wait_limit) fail_now("timeout waiting for a back-to-back command");
      end
    end
    wait_idle();
    check_drained();
    check_val("frame_sequences", seq_cnt - seq_before, n);
  endtask

  initial begin : stimulus
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    wait_reset_release();
    @(negedge clk);
    check_val("tx", tx, 1'b1);
    check_val("cmd_rdy", cmd_rdy, 1'b1);
    check_val("read_rdy", read_rdy, 1'b0);
    check_val("read_err", read_err, 1'b0);

    for (int i = 0; i < 6; i++) begin
      run_single(make_cmd(1'b1, 1'b0), mode_ok);
    end
    for (int i = 0; i < 6; i++) begin
      run_single(make_cmd(1'b0, 1'b0), mode_ok);
    end
    for (int i = 0; i < 2; i++) begin
      run_single(make_cmd(1'b0, 1'b0), mode_bad_par);
    end

    // with a silent slave the error must wait out the whole response window.
    run_single(make_cmd(1'b0, 1'b0), mode_silent);
    if (err_cycle - frame_end_cycle < `UART_RESP_BITS * bit_cycles) begin
      fail_now("read_err on a silent slave came before the response window ended");
    end

    run_back_to_back(10);

    repeat (4) @(posedge clk);
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* flist.f */
+incdir+rtl
rtl/uart_cmd_pkg.sv
rtl/uart_tx_engine.sv
rtl/uart_rx_engine.sv
rtl/uart_cmd_sequencer.sv
rtl/uart_cmd_master.sv
tb/tb_clk_gen.sv
tb/tb_uart_cmd_master.sv

/* Bender.yml */
package:
  name: uart_cmd_master

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/uart_cmd_pkg.sv
      - rtl/uart_tx_engine.sv
      - rtl/uart_rx_engine.sv
      - rtl/uart_cmd_sequencer.sv
      - rtl/uart_cmd_master.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_uart_cmd_master.sv
